// ==== common/muldiv_pkg.sv ====
// ----------------------------------------------------------
// shared definitions for the muldiv coprocessor
// op codes, register map, status bits and bus structs
// ----------------------------------------------------------
package muldiv_pkg;

  // operand width and iteration count of both engines
  localparam int XLEN       = 32;
  localparam int ITER_COUNT = 32;
  // counter runs 0..ITER_COUNT inclusive
  localparam int CNT_W      = $clog2(ITER_COUNT + 1);
  localparam int OP_W       = 2;
  localparam int APB_AW     = 8;

  // register map, byte addresses
  localparam logic [APB_AW-1:0] ADDR_OPA    = 8'h00;
  localparam logic [APB_AW-1:0] ADDR_OPB    = 8'h04;
  localparam logic [APB_AW-1:0] ADDR_CMD    = 8'h08;
  localparam logic [APB_AW-1:0] ADDR_STATUS = 8'h0C;
  localparam logic [APB_AW-1:0] ADDR_RES_LO = 8'h10;
  localparam logic [APB_AW-1:0] ADDR_RES_HI = 8'h14;

  // status word bit positions
  localparam int STAT_MUL_BUSY  = 0;
  localparam int STAT_DIV_BUSY  = 1;
  localparam int STAT_RES_VALID = 2;
  // low bit of the 2-bit op field of the buffered result
  localparam int STAT_RES_OP    = 4;

  // code 3 is unused, a command with it starts nothing
  typedef enum logic [OP_W-1:0] {
    OP_MUL  = 2'd0,
    OP_DIV  = 2'd1,
    OP_DIVU = 2'd2
  } op_e;

  typedef struct packed {
    op_e             op;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
  } muldiv_req_t;

  // divides pack remainder in the upper word, quotient in the lower
  typedef struct packed {
    op_e               op;
    logic [2*XLEN-1:0] result;
  } muldiv_resp_t;

  typedef struct packed {
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [APB_AW-1:0] paddr;
    logic [XLEN-1:0]   pwdata;
  } apb_req_t;

endpackage

// ==== divider/int_div_dpath.sv ====
// ----------------------------------------------------------
// divider datapath, restoring shift/subtract
// operand magnitudes, sign fix-up, divide-by-zero
// ----------------------------------------------------------
module int_div_dpath
  import muldiv_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  muldiv_req_t       req,
  input  logic              load,
  input  logic              step,
  input  logic              fixup,
  output logic [2*XLEN-1:0] result,
  output op_e               op
);

  // operand signs, zero for the unsigned op
  logic              a_neg;
  logic              b_neg;
  logic [XLEN-1:0]   a_mag;
  logic [XLEN-1:0]   b_mag;

  // {remainder, quotient} working register, one guard bit on top
  logic [2*XLEN:0]   rq_q;
  // divisor aligned to the remainder half
  logic [2*XLEN:0]   dvsr_q;
  logic [XLEN-1:0]   a_orig_q;
  logic              a_neg_q;
  logic              b_neg_q;
  logic              b_zero_q;
  op_e               op_q;
  logic [2*XLEN-1:0] result_q;

  logic [2*XLEN:0]   shifted;
  logic [2*XLEN:0]   diff;
  logic [XLEN-1:0]   quot;
  logic [XLEN-1:0]   rem;
  logic [XLEN-1:0]   quot_fix;
  logic [XLEN-1:0]   rem_fix;

  // ----------------------------------------------------------
  // operand magnitudes
  // ----------------------------------------------------------
  assign a_neg = (req.op == OP_DIV) & req.a[XLEN-1];
  assign b_neg = (req.op == OP_DIV) & req.b[XLEN-1];
  assign a_mag = a_neg ? (~req.a + 1'b1) : req.a;
  assign b_mag = b_neg ? (~req.b + 1'b1) : req.b;

  // ----------------------------------------------------------
  // restoring step
  // ----------------------------------------------------------
  assign shifted = rq_q << 1;
  assign diff    = shifted - dvsr_q;

  // fix-up on the magnitudes left after the last step
  assign quot     = rq_q[XLEN-1:0];
  assign rem      = rq_q[2*XLEN-1:XLEN];
  // quotient sign follows the xor of the operand signs
  assign quot_fix = (a_neg_q ^ b_neg_q) ? (~quot + 1'b1) : quot;
  // remainder takes the sign of the dividend
  assign rem_fix  = a_neg_q ? (~rem + 1'b1) : rem;

  // sign and zero flags
  always_ff @(posedge clk) begin
    if (reset) begin
      a_neg_q  <= 1'b0;
      b_neg_q  <= 1'b0;
      b_zero_q <= 1'b0;
      op_q     <= OP_DIV;
    end else if (load) begin
      a_neg_q  <= a_neg;
      b_neg_q  <= b_neg;
      b_zero_q <= (req.b == '0);
      op_q     <= req.op;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      rq_q     <= {{(XLEN+1){1'b0}}, a_mag};
      dvsr_q   <= {1'b0, b_mag, {XLEN{1'b0}}};
      a_orig_q <= req.a;
    end else if (step) begin
      // negative difference means restore, quotient bit zero
      if (diff[2*XLEN]) begin
        rq_q <= {shifted[2*XLEN:1], 1'b0};
      end else begin
        rq_q <= {diff[2*XLEN:1], 1'b1};
      end
    end
    if (fixup) begin
      if (b_zero_q) begin
        // x/0 gives all ones, remainder is the dividend untouched
        result_q <= {a_orig_q, {XLEN{1'b1}}};
      end else begin
        result_q <= {rem_fix, quot_fix};
      end
    end
  end

  assign result = result_q;
  assign op     = op_q;

endmodule

// ==== divider/int_div_iterative.sv ====
// ----------------------------------------------------------
// iterative divider, control FSM and val/rdy handshake
// ----------------------------------------------------------
module int_div_iterative
  import muldiv_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  muldiv_req_t  req,
  input  logic         req_val,
  output logic         req_rdy,
  output muldiv_resp_t resp,
  output logic         resp_val,
  input  logic         resp_rdy
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_CALC,
    S_FIXUP,
    S_DONE
  } state_e;

  state_e            state_q;
  logic [CNT_W-1:0]  count_q;
  logic              last_cnt;
  logic              load;
  logic              step;
  logic              fixup;
  logic [2*XLEN-1:0] result;
  op_e               op;

  // ----------------------------------------------------------
  // state register
  // ----------------------------------------------------------
  assign last_cnt = (count_q == CNT_W'(ITER_COUNT));

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= S_IDLE;
      count_q <= '0;
    end else begin
      case (state_q)
        S_IDLE: begin
          // accept only while idle
          if (req_val) begin
            state_q <= S_CALC;
            count_q <= '0;
          end
        end
        S_CALC: begin
          // steps on 0..ITER_COUNT-1, final count just hands over
          if (last_cnt) begin
            state_q <= S_FIXUP;
          end else begin
            count_q <= count_q + 1'b1;
          end
        end
        // one cycle for the sign fix-up
        S_FIXUP: state_q <= S_DONE;
        S_DONE: begin
          // hold the result until the arbiter takes it
          if (resp_rdy) begin
            state_q <= S_IDLE;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // ----------------------------------------------------------
  // datapath enables and handshake outputs
  // ----------------------------------------------------------
  assign req_rdy  = (state_q == S_IDLE);
  assign resp_val = (state_q == S_DONE);
  assign load     = req_rdy & req_val;
  assign step     = (state_q == S_CALC) & ~last_cnt;
  assign fixup    = (state_q == S_FIXUP);

  assign resp = '{op: op, result: result};

  int_div_dpath dpath0 (
    .clk    (clk),
    .reset  (reset),
    .req    (req),
    .load   (load),
    .step   (step),
    .fixup  (fixup),
    .result (result),
    .op     (op)
  );

endmodule

// ==== src.f ====
common/muldiv_pkg.sv
divider/int_div_dpath.sv
divider/int_div_iterative.sv
verilog/int_mul_iterative.sv
verilog/result_arbiter.sv
verilog/muldiv_apb_regs.sv
verilog/muldiv_top.sv
test/muldiv_props.sv
test/muldiv_tb.sv

// ==== test/muldiv_props.sv ====
// ----------------------------------------------------------
// concurrent assertions on the result arbiter, bound in
// ----------------------------------------------------------
module muldiv_props
  import muldiv_pkg::*;
(
  input logic         clk,
  input logic         reset,
  input muldiv_resp_t mul_resp,
  input logic         mul_val,
  input logic         mul_rdy,
  input muldiv_resp_t div_resp,
  input logic         div_val,
  input logic         div_rdy,
  input logic         res_valid
);

  // failures seen so far, read back by the testbench
  int fail_count = 0;

  // one grant per cycle
  one_grant: assert property (@(posedge clk) disable iff (reset) !(mul_rdy && div_rdy))
    else begin
      $error("both engines granted in the same cycle");
      fail_count++;
    end

  // a full buffer blocks both engines
  no_grant_when_full: assert property (@(posedge clk) disable iff (reset)
    !(res_valid && (mul_rdy || div_rdy)))
    else begin
      $error("engine granted while the result buffer is full");
      fail_count++;
    end

  // a waiting response must hold still
  mul_stable: assert property (@(posedge clk) disable iff (reset)
    (mul_val && !mul_rdy) |=> (mul_val && (mul_resp == $past(mul_resp))))
    else begin
      $error("multiplier response changed while waiting for a grant");
      fail_count++;
    end

  div_stable: assert property (@(posedge clk) disable iff (reset)
    (div_val && !div_rdy) |=> (div_val && (div_resp == $past(div_resp))))
    else begin
      $error("divider response changed while waiting for a grant");
      fail_count++;
    end

endmodule

bind result_arbiter muldiv_props props0 (
  .clk       (clk),
  .reset     (reset),
  .mul_resp  (mul_resp),
  .mul_val   (mul_val),
  .mul_rdy   (mul_rdy),
  .div_resp  (div_resp),
  .div_val   (div_val),
  .div_rdy   (div_rdy),
  .res_valid (res_valid)
);

// ==== test/muldiv_tb.sv ====
// ----------------------------------------------------------
// muldiv coprocessor testbench with APB tasks, xorshift
// stimulus, reference model and result checks
// ----------------------------------------------------------
module muldiv_tb
  import muldiv_pkg::*;
();

  localparam int POLL_LIMIT = 40;
  localparam logic [31:0] VALID_MASK = 32'h1 << STAT_RES_VALID;

  logic        clk = 1'b0;
  logic        reset;
  apb_req_t    apb;
  logic [31:0] prdata;
  logic        pslverr;
  logic [31:0] rng_state = 32'd87;
  int          val_errs;
  int          tmo_errs;

  always #2 clk = ~clk;

  muldiv_top dut0 (
    .clk     (clk),
    .reset   (reset),
    .apb     (apb),
    .prdata  (prdata),
    .pslverr (pslverr)
  );

  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
  endfunction

  // ----------------------------------------------------------
  // reference model with divides giving {remainder, quotient}
  // ----------------------------------------------------------
  function automatic logic [63:0] ref_result(op_e op, logic [31:0] a, logic [31:0] b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic [63:0]        q;
    logic [63:0]        r;
    sa = $signed(a);
    sb = $signed(b);
    if (op == OP_MUL) return sa * sb;
    // x/0 returns all ones and keeps the dividend
    if (b == 32'd0) return {a, 32'hffff_ffff};
    if (op == OP_DIVU) return {a % b, a / b};
    // wide math keeps min/-1 from overflowing
    q = sa / sb;
    r = sa % sb;
    return {r[31:0], q[31:0]};
  endfunction

  // ----------------------------------------------------------
  // APB access through setup, access, mid-access sample and idle
  // ----------------------------------------------------------
  task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    @(posedge clk);
    apb <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
    @(posedge clk);
    apb.penable <= 1'b1;
    @(negedge clk);
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    apb <= '0;
  endtask

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (exp === act) else begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      val_errs++;
    end
  endtask

  task automatic apb_write(input string name, input logic [7:0] addr, input logic [31:0] data,
                           input logic exp_err);
    logic [31:0] unused;
    logic        err;
    apb_xfer(1'b1, addr, data, unused, err);
    check_value({name, " pslverr"}, exp_err, err);
  endtask

  // reads never raise pslverr
  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
    logic err;
    apb_xfer(1'b0, addr, 32'd0, data, err);
    check_value($sformatf("read %h pslverr", addr), 1'b0, err);
  endtask

  // poll status until the masked bits match or the poll limit runs out
  task automatic wait_status(input string name, input logic [31:0] mask,
                             input logic [31:0] want, output logic [31:0] status);
    int n;
    for (n = 0; n < POLL_LIMIT; n++) begin
      apb_read(ADDR_STATUS, status);
      if ((status & mask) == want) break;
    end
    if (n == POLL_LIMIT) begin
      $display("%s: timed out waiting for the status register", name);
      tmo_errs++;
    end
  endtask

  // lower half read first since the upper half read pops the buffer
  task automatic read_result(input string name, output logic [63:0] res, output op_e op);
    logic [31:0] s;
    logic [31:0] lo;
    logic [31:0] hi;
    wait_status(name, VALID_MASK, VALID_MASK, s);
    op = op_e'(s[STAT_RES_OP +: OP_W]);
    apb_read(ADDR_RES_LO, lo);
    apb_read(ADDR_RES_HI, hi);
    res = {hi, lo};
  endtask

  task automatic start_op(input string name, input op_e op, input logic [31:0] a,
                          input logic [31:0] b);
    apb_write(name, ADDR_OPA, a, 1'b0);
    apb_write(name, ADDR_OPB, b, 1'b0);
    apb_write(name, ADDR_CMD, 32'(op), 1'b0);
  endtask

  task automatic run_op(input string name, input op_e op, input logic [31:0] a,
                        input logic [31:0] b);
    logic [63:0] got;
    op_e         got_op;
    start_op(name, op, a, b);
    read_result(name, got, got_op);
    check_value({name, " op"}, op, got_op);
    check_value(name, ref_result(op, a, b), got);
  endtask

  // second command to the same engine while it runs
  task automatic busy_check(input string name, input op_e op, input op_e op2);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] s;
    logic [63:0] got;
    op_e         got_op;
    a = xorshift32();
    b = xorshift32() >> 4;
    start_op(name, op, a, b);
    apb_write(name, ADDR_OPA, ~a, 1'b0);
    apb_write({name, " busy"}, ADDR_CMD, 32'(op2), 1'b1);
    read_result(name, got, got_op);
    check_value({name, " op"}, op, got_op);
    check_value(name, ref_result(op, a, b), got);
    // the rejected command must not have started anything
    apb_read(ADDR_STATUS, s);
    check_value({name, " idle status"}, 3'b000, s[2:0]);
  endtask

  // multiply and divide together with the buffer optionally left unread a while
  task automatic pair_run(input string name, input logic hold);
    logic [31:0] a1;
    logic [31:0] b1;
    logic [31:0] a2;
    logic [31:0] b2;
    logic [31:0] s;
    logic [63:0] got;
    op_e         got_op;
    logic        seen_mul;
    logic        seen_div;
    int          i;
    a1 = xorshift32();
    b1 = xorshift32();
    a2 = xorshift32();
    b2 = xorshift32() >> 8;
    seen_mul = 1'b0;
    seen_div = 1'b0;
    start_op(name, OP_MUL, a1, b1);
    start_op(name, OP_DIV, a2, b2);
    if (hold) begin
      wait_status(name, VALID_MASK, VALID_MASK, s);
      // product held while the divider waits behind it
      for (i = 0; i < 15; i++) begin
        apb_read(ADDR_STATUS, s);
        check_value({name, " held status"}, 3'b110, s[2:0]);
        check_value({name, " held op"}, OP_MUL, s[STAT_RES_OP +: OP_W]);
      end
    end
    repeat (2) begin
      read_result(name, got, got_op);
      if (got_op == OP_MUL) begin
        seen_mul = 1'b1;
        check_value({name, " mul"}, ref_result(OP_MUL, a1, b1), got);
      end else begin
        seen_div = 1'b1;
        check_value({name, " div op"}, OP_DIV, got_op);
        check_value({name, " div"}, ref_result(OP_DIV, a2, b2), got);
      end
    end
    assert (seen_mul && seen_div) else begin
      $display("%s: did not get one multiply result and one divide result", name);
      val_errs++;
    end
  endtask

  // ----------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------
  initial begin
    logic [31:0] s;
    logic [31:0] r;
    int          i;
    int          asrt_errs;
    reset    = 1'b1;
    apb      = '0;
    val_errs = 0;
    tmo_errs = 0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;

    apb_read(ADDR_STATUS, s);
    check_value("reset_status", 3'b000, s[2:0]);

    for (i = 0; i < 20; i++) begin
      run_op($sformatf("mul_rand_%0d", i), OP_MUL, xorshift32(), xorshift32());
    end

    // divisor shifted down by a random amount for useful quotients
    for (i = 0; i < 20; i++) begin
      r = xorshift32();
      run_op($sformatf("div_rand_%0d", i), r[0] ? OP_DIVU : OP_DIV, xorshift32(),
             xorshift32() >> r[8:4]);
    end

    run_op("div_zero", OP_DIV, 32'hdead_beef, 32'd0);
    run_op("divu_zero", OP_DIVU, 32'h1234_5678, 32'd0);
    run_op("div_min_neg1", OP_DIV, 32'h8000_0000, 32'hffff_ffff);
    run_op("div_neg_rem", OP_DIV, -32'sd7, 32'sd2);
    run_op("div_neg_divisor", OP_DIV, 32'sd7, -32'sd2);
    run_op("div_both_neg", OP_DIV, -32'sd7, -32'sd2);

    pair_run("pair", 1'b0);
    busy_check("busy_mul", OP_MUL, OP_MUL);
    busy_check("busy_div", OP_DIV, OP_DIVU);
    pair_run("backpressure", 1'b1);

    asrt_errs = dut0.arb0.props0.fail_count;
    $display("errors: value %0d, timeout %0d, assertion %0d", val_errs, tmo_errs, asrt_errs);
    if (val_errs == 0 && tmo_errs == 0 && asrt_errs == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== verilog/int_mul_iterative.sv ====
// ----------------------------------------------------------
// iterative shift-add signed multiplier
// idle/calc/done handshake and 64-bit accumulator
// ----------------------------------------------------------
module int_mul_iterative
  import muldiv_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  muldiv_req_t  req,
  input  logic         req_val,
  output logic         req_rdy,
  output muldiv_resp_t resp,
  output logic         resp_val,
  input  logic         resp_rdy
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_CALC,
    S_DONE
  } state_e;

  state_e            state_q;
  logic [CNT_W-1:0]  count_q;
  logic              last_cnt;
  logic              accept;
  logic              step;
  logic              finish;

  logic [XLEN-1:0]   a_mag;
  logic [XLEN-1:0]   b_mag;
  logic [2*XLEN-1:0] acc_q;
  // multiplicand shifts left, multiplier shifts right
  logic [2*XLEN-1:0] mcand_q;
  logic [XLEN-1:0]   mplier_q;
  logic              neg_q;

  // ----------------------------------------------------------
  // control
  // ----------------------------------------------------------
  assign last_cnt = (count_q == CNT_W'(ITER_COUNT));
  assign req_rdy  = (state_q == S_IDLE);
  assign resp_val = (state_q == S_DONE);
  assign accept   = req_rdy & req_val;
  assign step     = (state_q == S_CALC) & ~last_cnt;
  // the last count applies the product sign
  assign finish   = (state_q == S_CALC) & last_cnt;

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= S_IDLE;
      count_q <= '0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (req_val) begin
            state_q <= S_CALC;
            count_q <= '0;
          end
        end
        S_CALC: begin
          if (last_cnt) begin
            state_q <= S_DONE;
          end else begin
            count_q <= count_q + 1'b1;
          end
        end
        S_DONE: begin
          // wait here under back-pressure
          if (resp_rdy) begin
            state_q <= S_IDLE;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // ----------------------------------------------------------
  // datapath
  // ----------------------------------------------------------
  assign a_mag = req.a[XLEN-1] ? (~req.a + 1'b1) : req.a;
  assign b_mag = req.b[XLEN-1] ? (~req.b + 1'b1) : req.b;

  always_ff @(posedge clk) begin
    if (accept) begin
      acc_q    <= '0;
      mcand_q  <= {{XLEN{1'b0}}, a_mag};
      mplier_q <= b_mag;
      neg_q    <= req.a[XLEN-1] ^ req.b[XLEN-1];
    end else if (step) begin
      // add the shifted multiplicand for each set multiplier bit
      if (mplier_q[0]) begin
        acc_q <= acc_q + mcand_q;
      end
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end else if (finish && neg_q) begin
      acc_q <= ~acc_q + 1'b1;
    end
  end

  assign resp = '{op: OP_MUL, result: acc_q};

endmodule

// ==== verilog/muldiv_apb_regs.sv ====
// ----------------------------------------------------------
// APB register file for the muldiv coprocessor
// operands, command decode, status and result readout
// ----------------------------------------------------------
module muldiv_apb_regs
  import muldiv_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  apb_req_t     apb,
  output logic [31:0]  prdata,
  output logic         pslverr,
  output muldiv_req_t  mul_req,
  output logic         mul_req_val,
  input  logic         mul_req_rdy,
  output muldiv_req_t  div_req,
  output logic         div_req_val,
  input  logic         div_req_rdy,
  input  logic         res_valid,
  input  muldiv_resp_t res,
  output logic         res_pop
);

  logic [XLEN-1:0] opa_q;
  logic [XLEN-1:0] opb_q;
  logic            wr_acc;
  logic            rd_acc;
  logic            cmd_wr;
  op_e             cmd_op;
  logic            mul_hit;
  logic            div_hit;
  logic [XLEN-1:0] status;

  // access phase, no wait states
  assign wr_acc = apb.psel & apb.penable & apb.pwrite;
  assign rd_acc = apb.psel & apb.penable & ~apb.pwrite;

  // ----------------------------------------------------------
  // operand registers
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      opa_q <= '0;
      opb_q <= '0;
    end else if (wr_acc) begin
      if (apb.paddr == ADDR_OPA) begin
        opa_q <= apb.pwdata;
      end
      if (apb.paddr == ADDR_OPB) begin
        opb_q <= apb.pwdata;
      end
    end
  end

  // ----------------------------------------------------------
  // command decode
  // ----------------------------------------------------------
  assign cmd_wr  = wr_acc & (apb.paddr == ADDR_CMD);
  assign cmd_op  = op_e'(apb.pwdata[OP_W-1:0]);
  assign mul_hit = cmd_wr & (cmd_op == OP_MUL);
  assign div_hit = cmd_wr & ((cmd_op == OP_DIV) | (cmd_op == OP_DIVU));

  // engine accepts on the edge closing this access
  assign mul_req_val = mul_hit & mul_req_rdy;
  assign div_req_val = div_hit & div_req_rdy;
  // busy target, the command is dropped
  assign pslverr     = (mul_hit & ~mul_req_rdy) | (div_hit & ~div_req_rdy);

  assign mul_req = '{op: OP_MUL, a: opa_q, b: opb_q};
  assign div_req = '{op: cmd_op, a: opa_q, b: opb_q};

  // ----------------------------------------------------------
  // status and readout
  // ----------------------------------------------------------
  always_comb begin
    status                        = '0;
    status[STAT_MUL_BUSY]         = ~mul_req_rdy;
    status[STAT_DIV_BUSY]         = ~div_req_rdy;
    status[STAT_RES_VALID]        = res_valid;
    status[STAT_RES_OP +: OP_W]   = res.op;
  end

  always_comb begin
    prdata = '0;
    if (rd_acc) begin
      case (apb.paddr)
        ADDR_OPA:    prdata = opa_q;
        ADDR_OPB:    prdata = opb_q;
        ADDR_STATUS: prdata = status;
        ADDR_RES_LO: prdata = res.result[XLEN-1:0];
        ADDR_RES_HI: prdata = res.result[2*XLEN-1:XLEN];
        default:     prdata = '0;
      endcase
    end
  end

  // upper half read frees the buffer
  assign res_pop = rd_acc & (apb.paddr == ADDR_RES_HI) & res_valid;

endmodule

// ==== verilog/muldiv_top.sv ====
// ----------------------------------------------------------
// muldiv coprocessor top, APB regs, two engines, arbiter
// ----------------------------------------------------------
module muldiv_top
  import muldiv_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  apb_req_t    apb,
  output logic [31:0] prdata,
  output logic        pslverr
);

  // request side
  muldiv_req_t  mul_req;
  muldiv_req_t  div_req;
  logic         mul_req_val;
  logic         mul_req_rdy;
  logic         div_req_val;
  logic         div_req_rdy;

  // response side
  muldiv_resp_t mul_resp;
  muldiv_resp_t div_resp;
  logic         mul_resp_val;
  logic         mul_resp_rdy;
  logic         div_resp_val;
  logic         div_resp_rdy;

  // result buffer
  logic         res_valid;
  muldiv_resp_t res;
  logic         res_pop;

  muldiv_apb_regs regs0 (
    .clk         (clk),
    .reset       (reset),
    .apb         (apb),
    .prdata      (prdata),
    .pslverr     (pslverr),
    .mul_req     (mul_req),
    .mul_req_val (mul_req_val),
    .mul_req_rdy (mul_req_rdy),
    .div_req     (div_req),
    .div_req_val (div_req_val),
    .div_req_rdy (div_req_rdy),
    .res_valid   (res_valid),
    .res         (res),
    .res_pop     (res_pop)
  );

  int_mul_iterative mul0 (
    .clk      (clk),
    .reset    (reset),
    .req      (mul_req),
    .req_val  (mul_req_val),
    .req_rdy  (mul_req_rdy),
    .resp     (mul_resp),
    .resp_val (mul_resp_val),
    .resp_rdy (mul_resp_rdy)
  );

  int_div_iterative div0 (
    .clk      (clk),
    .reset    (reset),
    .req      (div_req),
    .req_val  (div_req_val),
    .req_rdy  (div_req_rdy),
    .resp     (div_resp),
    .resp_val (div_resp_val),
    .resp_rdy (div_resp_rdy)
  );

  result_arbiter arb0 (
    .clk       (clk),
    .reset     (reset),
    .mul_resp  (mul_resp),
    .mul_val   (mul_resp_val),
    .mul_rdy   (mul_resp_rdy),
    .div_resp  (div_resp),
    .div_val   (div_resp_val),
    .div_rdy   (div_resp_rdy),
    .res_pop   (res_pop),
    .res_valid (res_valid),
    .res       (res)
  );

endmodule

// ==== verilog/result_arbiter.sv ====
// ----------------------------------------------------------
// round-robin result arbiter and one-entry result buffer
// ----------------------------------------------------------
module result_arbiter
  import muldiv_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  muldiv_resp_t mul_resp,
  input  logic         mul_val,
  output logic         mul_rdy,
  input  muldiv_resp_t div_resp,
  input  logic         div_val,
  output logic         div_rdy,
  input  logic         res_pop,
  output logic         res_valid,
  output muldiv_resp_t res
);

  // set when the divider wins the next tie
  logic         prio_div_q;
  logic         res_valid_q;
  muldiv_resp_t res_q;

  // grant only into an empty buffer, at most one engine
  assign mul_rdy = ~res_valid_q & mul_val & (~div_val | ~prio_div_q);
  assign div_rdy = ~res_valid_q & div_val & (~mul_val | prio_div_q);

  always_ff @(posedge clk) begin
    if (reset) begin
      prio_div_q  <= 1'b0;
      res_valid_q <= 1'b0;
    end else if (mul_rdy | div_rdy) begin
      res_valid_q <= 1'b1;
      // the loser of this grant goes first next time
      prio_div_q  <= mul_rdy;
    end else if (res_pop) begin
      res_valid_q <= 1'b0;
    end
  end

  // buffer loads on the granting edge
  always_ff @(posedge clk) begin
    if (mul_rdy) begin
      res_q <= mul_resp;
    end else if (div_rdy) begin
      res_q <= div_resp;
    end
  end

  assign res_valid = res_valid_q;
  assign res       = res_q;

endmodule
